// ==== video_controller.f ====
+incdir+include
logic/video_pkg.sv
logic/raster_timing.sv
logic/text_buffer.sv
logic/text_decode.sv
logic/pixel_execute.sv
logic/pixel_result.sv
logic/video_controller.sv
verification/video_checker.sv
verification/video_controller_tb.sv

// ==== Bender.yml ====
package:
  name: video_controller

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/video_pkg.sv
      - logic/raster_timing.sv
      - logic/text_buffer.sv
      - logic/text_decode.sv
      - logic/pixel_execute.sv
      - logic/pixel_result.sv
      - logic/video_controller.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/video_checker.sv
      - verification/video_controller_tb.sv

// ==== verification/video_controller_testdata.txt ====
// Header: font row count, command count, frames to check
// Font rows: address bitmap. Commands: frames to skip, opcode, cell address, data
7 8 4
0014 8001
0019 F0F0
0025 FFFF
002B AAAA
0032 1234
003B 0FF0
4FEC C3C3
0 0 0 1E000001
0 0 3 4B010002
0 0 9 0F020001
0 0 F 270303FF
0 1 0 00002081
1 0 3 5C000002
1 1 0 00000081
0 1 0 00002003

// ==== verification/video_controller_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_controller_tb;

	localparam int CLOCK_PERIOD = 10;
	localparam int DATA_WORDS = 64;
	localparam int FONT_ROWS = 2 ** video_pkg::FONT_ADDR_WIDTH;
	localparam int MAX_GAP = 400;

	logic clk;
	logic reset;
	logic cmd_valid;
	logic cmd_ready;
	video_pkg::video_op_e cmd_op;
	logic [video_pkg::CELL_ADDR_WIDTH-1:0] cmd_address;
	logic [video_pkg::CELL_WIDTH-1:0] cmd_data;
	logic [video_pkg::FONT_ADDR_WIDTH-1:0] font_address;
	logic [video_pkg::FONT_ADDR_WIDTH-1:0] font_address_q = '0;
	logic [video_pkg::CHAR_WIDTH-1:0] char_row_bitmap = '0;
	logic hsync;
	logic vsync;
	logic pixel_active;
	logic [video_pkg::CHANNEL_WIDTH-1:0] pixel_red;
	logic [video_pkg::CHANNEL_WIDTH-1:0] pixel_green;
	logic [video_pkg::CHANNEL_WIDTH-1:0] pixel_blue;

	logic [31:0] test_data [DATA_WORDS];
	logic [video_pkg::CHAR_WIDTH-1:0] font_rom [FONT_ROWS];
	int font_count;
	int cmd_count;
	int frame_count;
	logic data_loaded = 1'b0;
	int value_errors;
	int timing_errors;
	int accepted_count;
	int checked_pixels;

	video_controller UUT (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd_op(cmd_op),
		.cmd_address(cmd_address),
		.cmd_data(cmd_data),
		.font_address(font_address),
		.char_row_bitmap(char_row_bitmap),
		.hsync(hsync),
		.vsync(vsync),
		.pixel_active(pixel_active),
		.pixel_red(pixel_red),
		.pixel_green(pixel_green),
		.pixel_blue(pixel_blue)
	);

	video_checker monitor (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd_op(cmd_op),
		.cmd_address(cmd_address),
		.cmd_data(cmd_data),
		.hsync(hsync),
		.vsync(vsync),
		.pixel_active(pixel_active),
		.pixel_red(pixel_red),
		.pixel_green(pixel_green),
		.pixel_blue(pixel_blue),
		.value_errors(value_errors),
		.timing_errors(timing_errors),
		.accepted_count(accepted_count),
		.checked_pixels(checked_pixels)
	);

	initial begin
		clk = 1'b0;
		forever #(CLOCK_PERIOD / 2) clk = ~clk;
	end

	// Font ROM model with one cycle of latency
	always @(posedge clk)
		font_address_q <= font_address;

	always @(negedge clk)
		char_row_bitmap <= font_rom[font_address_q];

	// ==============================
	// Data file and commands
	// ==============================
	task automatic load_test_data();
		int addr;
		int i;
		for (addr = 0; addr < FONT_ROWS; addr++)
			font_rom[addr] = '0;
		$readmemh("verification/video_controller_testdata.txt", test_data);
		font_count = test_data[0];
		cmd_count = test_data[1];
		frame_count = test_data[2];
		for (i = 0; i < font_count; i++)
			font_rom[test_data[3 + 2 * i]] = test_data[4 + 2 * i][video_pkg::CHAR_WIDTH-1:0];
	endtask

	// Holds the command until cmd_ready is seen
	task automatic send_command(input logic [1:0] op, input logic [31:0] address,
		input logic [31:0] data);
		@(negedge clk);
		cmd_valid = 1'b1;
		cmd_op = video_pkg::video_op_e'(op);
		cmd_address = video_pkg::CELL_ADDR_WIDTH'(address);
		cmd_data = data;
		while (!cmd_ready)
			@(negedge clk);
		@(negedge clk);
		cmd_valid = 1'b0;
	endtask

	task automatic report_results();
		if (accepted_count != cmd_count)
			$display("Command count mismatch, %0d accepted and %0d in the data file",
				accepted_count, cmd_count);
		if (checked_pixels == 0)
			$display("No active pixel was compared");
		$display("Errors: %0d value, %0d timing; %0d of %0d commands accepted, %0d pixels checked",
			value_errors, timing_errors, accepted_count, cmd_count, checked_pixels);
		if (value_errors == 0 && timing_errors == 0 && accepted_count == cmd_count
			&& checked_pixels > 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
	endtask

	initial begin : stimulus
		int base;
		int i;
		int unsigned gap;
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd_op = video_pkg::OP_WRITE_CELL;
		cmd_address = '0;
		cmd_data = '0;
		gap = $urandom(32'h58f8_cf4a);
		load_test_data();
		data_loaded = 1'b1;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		for (i = 0; i < cmd_count; i++) begin
			base = 3 + 2 * font_count + 4 * i;
			repeat (test_data[base]) @(negedge vsync);
			gap = $urandom % MAX_GAP;
			repeat (gap) @(negedge clk);
			send_command(test_data[base + 1][1:0], test_data[base + 2], test_data[base + 3]);
		end
		repeat (frame_count) @(negedge vsync);
		repeat (8) @(negedge clk);
		report_results();
		$finish;
	end

	initial begin : watchdog
		wait (data_loaded === 1'b1);
		#((cmd_count + frame_count + 3) * video_pkg::HORZ_TOTAL * video_pkg::VERT_TOTAL
			* CLOCK_PERIOD);
		$display("Timeout: the run did not finish within the expected number of frames");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/video_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_checker (
	input wire clk,
	input wire reset,
	input wire cmd_valid,
	input wire cmd_ready,
	input wire video_pkg::video_op_e cmd_op,
	input wire [video_pkg::CELL_ADDR_WIDTH-1:0] cmd_address,
	input wire [video_pkg::CELL_WIDTH-1:0] cmd_data,
	input wire hsync,
	input wire vsync,
	input wire pixel_active,
	input wire [video_pkg::CHANNEL_WIDTH-1:0] pixel_red,
	input wire [video_pkg::CHANNEL_WIDTH-1:0] pixel_green,
	input wire [video_pkg::CHANNEL_WIDTH-1:0] pixel_blue,
	output int value_errors,
	output int timing_errors,
	output int accepted_count,
	output int checked_pixels
);

	`include "ansi_palette.svh"

	localparam int VSYNC_CYCLES = video_pkg::VERT_SYNC * video_pkg::HORZ_TOTAL;

	// Mirror of the cell memory and cursor, built from accepted commands
	logic [video_pkg::CELL_WIDTH-1:0] cell_mirror [video_pkg::CELL_COUNT];
	logic cell_written [video_pkg::CELL_COUNT];
	logic cursor_visible;
	int cursor_row;
	int cursor_col;

	int value_error_count = 0;
	int timing_error_count = 0;
	int accept_count = 0;
	int pixel_count = 0;
	int pix_in_run;
	int run_count;
	int hsync_count;
	int hsync_low;
	int vsync_low;
	logic prev_active;
	logic prev_hsync;
	logic prev_vsync;
	logic frame_started;
	logic in_reset = 1'b0;

	assign value_errors = value_error_count;
	assign timing_errors = timing_error_count;
	assign accepted_count = accept_count;
	assign checked_pixels = pixel_count;

	task automatic check_value(input string name, input logic [8:0] expected,
		input logic [8:0] actual);
		if (actual !== expected) begin
			value_error_count++;
			$display("Error: %s expected 0x%0h actual 0x%0h at time %0t",
				name, expected, actual, $time);
		end
	endtask

	task automatic timing_error(input string message);
		timing_error_count++;
		$display("%s at time %0t", message, $time);
	endtask

	// ==============================
	// Pixel prediction
	// ==============================
	function automatic logic [video_pkg::COLOR_DEPTH-1:0] expected_color(input int line,
		input int px, input int cell_index);
		logic [video_pkg::CELL_WIDTH-1:0] word;
		logic [video_pkg::CHAR_WIDTH-1:0] bitmap;
		logic [3:0] fg_idx;
		logic [3:0] bg_idx;
		logic [video_pkg::COLOR_DEPTH-1:0] color;
		int char_row;
		int font_addr;
		word = cell_mirror[cell_index];
		char_row = line % video_pkg::CHAR_HEIGHT;
		fg_idx = word[video_pkg::FG_MSB:video_pkg::FG_LSB];
		bg_idx = word[video_pkg::BG_MSB:video_pkg::BG_LSB];
		// Invert swaps the two colours
		if (word[video_pkg::INVERT_BIT]) begin
			fg_idx = word[video_pkg::BG_MSB:video_pkg::BG_LSB];
			bg_idx = word[video_pkg::FG_MSB:video_pkg::FG_LSB];
		end
		font_addr = word[video_pkg::CODE_WIDTH-1:0] * video_pkg::CHAR_HEIGHT + char_row;
		bitmap = video_controller_tb.font_rom[font_addr];
		if (bitmap[video_pkg::CHAR_WIDTH - 1 - px % video_pkg::CHAR_WIDTH]
			|| (word[video_pkg::UNDERLINE_BIT] && char_row == video_pkg::UNDERLINE_ROW))
			color = ANSI_PALETTE[fg_idx];
		else
			color = ANSI_PALETTE[bg_idx];
		if (cursor_visible && cursor_row < video_pkg::ROWS && cursor_col < video_pkg::COLUMNS
			&& cursor_row * video_pkg::COLUMNS + cursor_col == cell_index)
			color = ~color;
		return color;
	endfunction

	always @(posedge clk) begin : compare
		int cell_index;
		logic [video_pkg::COLOR_DEPTH-1:0] expected;
		if (reset) begin
			// Outputs are only defined once reset has been seen on an edge
			if (in_reset && pixel_active !== 1'b0)
				timing_error("pixel_active is high during reset");
			if (in_reset && cmd_ready !== 1'b0)
				timing_error("cmd_ready is high during reset");
			in_reset = 1'b1;
			for (int c = 0; c < video_pkg::CELL_COUNT; c++)
				cell_written[c] = 1'b0;
			cursor_visible = 1'b0;
			cursor_row = 0;
			cursor_col = 0;
			pix_in_run = 0;
			run_count = 0;
			hsync_count = 0;
			hsync_low = 0;
			vsync_low = 0;
			prev_active = 1'b0;
			prev_hsync = 1'b1;
			prev_vsync = 1'b1;
			frame_started = 1'b0;
		end else begin
			in_reset = 1'b0;
			if (cmd_valid && cmd_ready) begin
				accept_count++;
				if (cmd_op == video_pkg::OP_WRITE_CELL) begin
					cell_mirror[cmd_address] = cmd_data;
					cell_written[cmd_address] = 1'b1;
				end else if (cmd_op == video_pkg::OP_CURSOR_POSITION) begin
					cursor_visible = cmd_data[video_pkg::CURSOR_VISIBLE_BIT];
					cursor_row = cmd_data[video_pkg::CURSOR_ROW_MSB:video_pkg::CURSOR_ROW_LSB];
					cursor_col = cmd_data[video_pkg::CURSOR_COL_MSB:0];
				end
			end

			// Active pixels in raster order
			if (pixel_active) begin
				if (cmd_ready)
					timing_error("cmd_ready is high while a visible line is scanned");
				if (run_count < video_pkg::VERT_VISIBLE && pix_in_run < video_pkg::HORZ_VISIBLE) begin
					cell_index = (run_count / video_pkg::CHAR_HEIGHT) * video_pkg::COLUMNS
						+ pix_in_run / video_pkg::CHAR_WIDTH;
					// Cells never written hold unknown words
					if (cell_written[cell_index]) begin
						expected = expected_color(run_count, pix_in_run, cell_index);
						check_value("pixel_red", expected[8:6], pixel_red);
						check_value("pixel_green", expected[5:3], pixel_green);
						check_value("pixel_blue", expected[2:0], pixel_blue);
						pixel_count++;
					end
				end
				pix_in_run++;
			end else begin
				check_value("pixel_red", 9'h0, pixel_red);
				check_value("pixel_green", 9'h0, pixel_green);
				check_value("pixel_blue", 9'h0, pixel_blue);
				if (prev_active) begin
					if (pix_in_run != video_pkg::HORZ_VISIBLE)
						timing_error($sformatf("Active run of %0d pixels instead of %0d",
							pix_in_run, video_pkg::HORZ_VISIBLE));
					run_count++;
					pix_in_run = 0;
				end
			end

			// ==============================
			// Sync pulses
			// ==============================
			if (!hsync)
				hsync_low++;
			if (!hsync && prev_hsync)
				hsync_count++;
			if (hsync && !prev_hsync) begin
				if (hsync_low != video_pkg::HORZ_SYNC)
					timing_error($sformatf("hsync was low for %0d cycles", hsync_low));
				hsync_low = 0;
			end
			if (!vsync)
				vsync_low++;
			if (!vsync && prev_vsync) begin
				// First frame after reset is partial
				if (frame_started && hsync_count != video_pkg::VERT_TOTAL)
					timing_error($sformatf("Frame had %0d hsync pulses", hsync_count));
				if (frame_started && run_count != video_pkg::VERT_VISIBLE)
					timing_error($sformatf("Frame had %0d active runs", run_count));
				frame_started = 1'b1;
				hsync_count = 0;
				run_count = 0;
			end
			if (vsync && !prev_vsync) begin
				if (vsync_low != VSYNC_CYCLES)
					timing_error($sformatf("vsync was low for %0d cycles", vsync_low));
				vsync_low = 0;
			end
			prev_active = pixel_active;
			prev_hsync = hsync;
			prev_vsync = vsync;
		end
	end

endmodule

`default_nettype wire

// ==== logic/video_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_controller (
	input wire clk,
	input wire reset,
	input wire cmd_valid,
	output logic cmd_ready,
	input wire video_pkg::video_op_e cmd_op,
	input wire [video_pkg::CELL_ADDR_WIDTH-1:0] cmd_address,
	input wire [video_pkg::CELL_WIDTH-1:0] cmd_data,
	output logic [video_pkg::FONT_ADDR_WIDTH-1:0] font_address,
	input wire [video_pkg::CHAR_WIDTH-1:0] char_row_bitmap,
	output logic hsync,
	output logic vsync,
	output logic pixel_active,
	output logic [video_pkg::CHANNEL_WIDTH-1:0] pixel_red,
	output logic [video_pkg::CHANNEL_WIDTH-1:0] pixel_green,
	output logic [video_pkg::CHANNEL_WIDTH-1:0] pixel_blue
);

	logic raster_hsync;
	logic raster_vsync;
	logic raster_visible;
	logic line_visible;
	logic [video_pkg::CELL_ADDR_WIDTH-1:0] cell_index;
	logic [video_pkg::CHAR_ROW_WIDTH-1:0] char_row;
	logic [video_pkg::PIXEL_SEL_WIDTH-1:0] pixel_in_cell;

	// Raster position aligned with the registered cell word
	logic visible_s1;
	logic [video_pkg::CHAR_ROW_WIDTH-1:0] char_row_s1;
	logic [video_pkg::PIXEL_SEL_WIDTH-1:0] pixel_in_cell_s1;

	logic [video_pkg::CELL_WIDTH-1:0] cell_word;
	logic cursor_hit;
	logic [video_pkg::COLOR_INDEX_WIDTH-1:0] fg;
	logic [video_pkg::COLOR_INDEX_WIDTH-1:0] bg;
	logic underline_now;
	logic cursor_s2;
	logic [video_pkg::PIXEL_SEL_WIDTH-1:0] pixel_sel;
	logic visible_s2;
	logic [video_pkg::COLOR_INDEX_WIDTH-1:0] color_index;
	logic cursor_s3;
	logic visible_s3;
	logic [video_pkg::SYNC_DELAY-1:0] hsync_pipe;
	logic [video_pkg::SYNC_DELAY-1:0] vsync_pipe;

	raster_timing raster (
		.clk(clk),
		.reset(reset),
		.hsync(raster_hsync),
		.vsync(raster_vsync),
		.visible(raster_visible),
		.line_visible(line_visible),
		.cell_index(cell_index),
		.char_row(char_row),
		.pixel_in_cell(pixel_in_cell)
	);

	text_buffer buffer (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd_op(cmd_op),
		.cmd_address(cmd_address),
		.cmd_data(cmd_data),
		.line_visible(line_visible),
		.cell_index(cell_index),
		.cell_word(cell_word),
		.cursor_hit(cursor_hit)
	);

	always_ff @(posedge clk) begin
		visible_s1 <= raster_visible;
		char_row_s1 <= char_row;
		pixel_in_cell_s1 <= pixel_in_cell;
	end

	text_decode decode (
		.clk(clk),
		.cell_word(cell_word),
		.cursor_hit(cursor_hit),
		.char_row(char_row_s1),
		.pixel_in_cell(pixel_in_cell_s1),
		.visible(visible_s1),
		.font_address(font_address),
		.fg(fg),
		.bg(bg),
		.underline_now(underline_now),
		.cursor_out(cursor_s2),
		.pixel_sel(pixel_sel),
		.visible_out(visible_s2)
	);

	pixel_execute execute (
		.clk(clk),
		.fg(fg),
		.bg(bg),
		.underline_now(underline_now),
		.cursor_in(cursor_s2),
		.pixel_sel(pixel_sel),
		.visible_in(visible_s2),
		.char_row_bitmap(char_row_bitmap),
		.color_index(color_index),
		.cursor_out(cursor_s3),
		.visible_out(visible_s3)
	);

	pixel_result result (
		.clk(clk),
		.reset(reset),
		.color_index(color_index),
		.cursor_in(cursor_s3),
		.visible_in(visible_s3),
		.pixel_red(pixel_red),
		.pixel_green(pixel_green),
		.pixel_blue(pixel_blue),
		.pixel_active(pixel_active)
	);

	// ==============================
	// Sync delay
	// ==============================
	// Syncs follow the pixel pipeline so all outputs line up
	always_ff @(posedge clk) begin
		if (reset) begin
			hsync_pipe <= '1;
			vsync_pipe <= '1;
		end else begin
			hsync_pipe <= {hsync_pipe[video_pkg::SYNC_DELAY-2:0], raster_hsync};
			vsync_pipe <= {vsync_pipe[video_pkg::SYNC_DELAY-2:0], raster_vsync};
		end
	end

	assign hsync = hsync_pipe[video_pkg::SYNC_DELAY-1];
	assign vsync = vsync_pipe[video_pkg::SYNC_DELAY-1];

endmodule

`default_nettype wire

// ==== logic/pixel_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_result (
	input wire clk,
	input wire reset,
	input wire [video_pkg::COLOR_INDEX_WIDTH-1:0] color_index,
	input wire cursor_in,
	input wire visible_in,
	output logic [video_pkg::CHANNEL_WIDTH-1:0] pixel_red,
	output logic [video_pkg::CHANNEL_WIDTH-1:0] pixel_green,
	output logic [video_pkg::CHANNEL_WIDTH-1:0] pixel_blue,
	output logic pixel_active
);

	`include "ansi_palette.svh"

	logic [video_pkg::COLOR_DEPTH-1:0] palette_color;
	logic [video_pkg::COLOR_DEPTH-1:0] shown_color;

	assign palette_color = ANSI_PALETTE[color_index];

	// Text cursor shows the complement of the cell colour
	assign shown_color = cursor_in ? ~palette_color : palette_color;

	always_ff @(posedge clk) begin
		if (reset || !visible_in) begin
			pixel_red <= '0;
			pixel_green <= '0;
			pixel_blue <= '0;
			pixel_active <= 1'b0;
		end else begin
			pixel_red <= shown_color[3*video_pkg::CHANNEL_WIDTH-1:2*video_pkg::CHANNEL_WIDTH];
			pixel_green <= shown_color[2*video_pkg::CHANNEL_WIDTH-1:video_pkg::CHANNEL_WIDTH];
			pixel_blue <= shown_color[video_pkg::CHANNEL_WIDTH-1:0];
			pixel_active <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/pixel_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_execute (
	input wire clk,
	input wire [video_pkg::COLOR_INDEX_WIDTH-1:0] fg,
	input wire [video_pkg::COLOR_INDEX_WIDTH-1:0] bg,
	input wire underline_now,
	input wire cursor_in,
	input wire [video_pkg::PIXEL_SEL_WIDTH-1:0] pixel_sel,
	input wire visible_in,
	input wire [video_pkg::CHAR_WIDTH-1:0] char_row_bitmap,
	output logic [video_pkg::COLOR_INDEX_WIDTH-1:0] color_index,
	output logic cursor_out,
	output logic visible_out
);

	logic font_bit;

	// MSB of the bitmap is the leftmost pixel
	assign font_bit = char_row_bitmap[~pixel_sel];

	always_ff @(posedge clk) begin
		// Underline row is solid foreground
		if (font_bit || underline_now)
			color_index <= fg;
		else
			color_index <= bg;
		cursor_out <= cursor_in;
		visible_out <= visible_in;
	end

endmodule

`default_nettype wire

// ==== logic/text_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module text_decode (
	input wire clk,
	input wire [video_pkg::CELL_WIDTH-1:0] cell_word,
	input wire cursor_hit,
	input wire [video_pkg::CHAR_ROW_WIDTH-1:0] char_row,
	input wire [video_pkg::PIXEL_SEL_WIDTH-1:0] pixel_in_cell,
	input wire visible,
	output logic [video_pkg::FONT_ADDR_WIDTH-1:0] font_address,
	output logic [video_pkg::COLOR_INDEX_WIDTH-1:0] fg,
	output logic [video_pkg::COLOR_INDEX_WIDTH-1:0] bg,
	output logic underline_now,
	output logic cursor_out,
	output logic [video_pkg::PIXEL_SEL_WIDTH-1:0] pixel_sel,
	output logic visible_out
);

	logic [video_pkg::FONT_ADDR_WIDTH-1:0] code_ext;
	logic [video_pkg::FONT_ADDR_WIDTH-1:0] row_ext;

	assign code_ext = {
		{(video_pkg::FONT_ADDR_WIDTH - video_pkg::CODE_WIDTH){1'b0}},
		cell_word[video_pkg::CODE_WIDTH-1:0]
	};
	assign row_ext = {
		{(video_pkg::FONT_ADDR_WIDTH - video_pkg::CHAR_ROW_WIDTH){1'b0}},
		char_row
	};

	// code * 20 as code * 16 + code * 4
	assign font_address = (code_ext << 4) + (code_ext << 2) + row_ext;

	always_ff @(posedge clk) begin
		if (cell_word[video_pkg::INVERT_BIT]) begin
			fg <= cell_word[video_pkg::BG_MSB:video_pkg::BG_LSB];
			bg <= cell_word[video_pkg::FG_MSB:video_pkg::FG_LSB];
		end else begin
			fg <= cell_word[video_pkg::FG_MSB:video_pkg::FG_LSB];
			bg <= cell_word[video_pkg::BG_MSB:video_pkg::BG_LSB];
		end
		underline_now <= cell_word[video_pkg::UNDERLINE_BIT]
			&& char_row == video_pkg::UNDERLINE_ROW;
		cursor_out <= cursor_hit;
		pixel_sel <= pixel_in_cell;
		visible_out <= visible;
	end

endmodule

`default_nettype wire

// ==== logic/text_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module text_buffer (
	input wire clk,
	input wire reset,
	input wire cmd_valid,
	output logic cmd_ready,
	input wire video_pkg::video_op_e cmd_op,
	input wire [video_pkg::CELL_ADDR_WIDTH-1:0] cmd_address,
	input wire [video_pkg::CELL_WIDTH-1:0] cmd_data,
	input wire line_visible,
	input wire [video_pkg::CELL_ADDR_WIDTH-1:0] cell_index,
	output logic [video_pkg::CELL_WIDTH-1:0] cell_word,
	output logic cursor_hit
);

	logic [video_pkg::CELL_WIDTH-1:0] cell_mem [video_pkg::CELL_COUNT];
	logic [video_pkg::CELL_ADDR_WIDTH-1:0] mem_address;
	logic [video_pkg::CURSOR_ROW_MSB-video_pkg::CURSOR_ROW_LSB:0] cursor_row;
	logic [video_pkg::CURSOR_COL_MSB:0] cursor_col;
	logic [video_pkg::CURSOR_LINEAR_WIDTH-1:0] cursor_linear;
	logic cursor_visible;
	logic accept;
	logic write_cell;

	// ==============================
	// Command port
	// ==============================
	// Ready only outside visible lines, so the memory port is free
	always_ff @(posedge clk) begin
		if (reset)
			cmd_ready <= 1'b0;
		else
			cmd_ready <= !line_visible;
	end

	assign accept = cmd_valid && cmd_ready;
	assign write_cell = accept && cmd_op == video_pkg::OP_WRITE_CELL;

	always_ff @(posedge clk) begin
		if (reset) begin
			cursor_visible <= 1'b0;
			cursor_row <= '0;
			cursor_col <= '0;
		end else if (accept && cmd_op == video_pkg::OP_CURSOR_POSITION) begin
			cursor_visible <= cmd_data[video_pkg::CURSOR_VISIBLE_BIT];
			cursor_row <= cmd_data[video_pkg::CURSOR_ROW_MSB:video_pkg::CURSOR_ROW_LSB];
			cursor_col <= cmd_data[video_pkg::CURSOR_COL_MSB:0];
		end
	end

	// ==============================
	// Cell memory
	// ==============================
	// Single port, writes borrow the address from the raster
	assign mem_address = write_cell ? cmd_address : cell_index;
	assign cursor_linear = cursor_row * video_pkg::CURSOR_STRIDE + cursor_col;

	always_ff @(posedge clk) begin
		if (write_cell)
			cell_mem[mem_address] <= cmd_data;
		cell_word <= cell_mem[mem_address];
		cursor_hit <= cursor_visible
			&& cursor_row < video_pkg::ROWS
			&& cursor_col < video_pkg::COLUMNS
			&& cursor_linear == cell_index;
	end

endmodule

`default_nettype wire

// ==== logic/raster_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module raster_timing (
	input wire clk,
	input wire reset,
	output logic hsync,
	output logic vsync,
	output logic visible,
	output logic line_visible,
	output logic [video_pkg::CELL_ADDR_WIDTH-1:0] cell_index,
	output logic [video_pkg::CHAR_ROW_WIDTH-1:0] char_row,
	output logic [video_pkg::PIXEL_SEL_WIDTH-1:0] pixel_in_cell
);

	logic [video_pkg::XPOS_WIDTH-1:0] xpos;
	logic [video_pkg::YPOS_WIDTH-1:0] ypos;
	logic [video_pkg::CELL_ADDR_WIDTH-1:0] column;
	logic [video_pkg::CELL_ADDR_WIDTH-1:0] row_base;
	logic line_end;
	logic x_visible;
	logic y_visible;

	assign line_end = xpos == video_pkg::HORZ_TOTAL - 1;

	// ==============================
	// Pixel and line counters
	// ==============================
	always_ff @(posedge clk) begin
		if (reset) begin
			xpos <= '0;
			ypos <= '0;
		end else if (line_end) begin
			xpos <= '0;
			if (ypos == video_pkg::VERT_TOTAL - 1)
				ypos <= '0;
			else
				ypos <= ypos + 1'b1;
		end else begin
			xpos <= xpos + 1'b1;
		end
	end

	assign x_visible = xpos >= video_pkg::HORZ_VISIBLE_START
		&& xpos < video_pkg::HORZ_VISIBLE_START + video_pkg::HORZ_VISIBLE;
	assign y_visible = ypos >= video_pkg::VERT_VISIBLE_START
		&& ypos < video_pkg::VERT_VISIBLE_START + video_pkg::VERT_VISIBLE;

	// Syncs are active low from sync start to the end of line or frame
	assign hsync = xpos < video_pkg::HORZ_SYNC_START;
	assign vsync = ypos < video_pkg::VERT_SYNC_START;
	assign visible = x_visible && y_visible;

	// Also set on the last pixel before the first visible line
	assign line_visible = y_visible
		|| (line_end && ypos == video_pkg::VERT_VISIBLE_START - 1);

	// ==============================
	// Cell coordinates
	// ==============================
	// Column counters restart every line and only run over visible pixels
	always_ff @(posedge clk) begin
		if (reset || line_end) begin
			pixel_in_cell <= '0;
			column <= '0;
		end else if (x_visible) begin
			pixel_in_cell <= pixel_in_cell + 1'b1;
			if (pixel_in_cell == video_pkg::CHAR_WIDTH - 1)
				column <= column + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			char_row <= '0;
			row_base <= '0;
		end else if (line_end) begin
			if (!y_visible) begin
				char_row <= '0;
				row_base <= '0;
			end else if (char_row == video_pkg::CHAR_HEIGHT - 1) begin
				char_row <= '0;
				row_base <= row_base + video_pkg::ROW_STRIDE;
			end else begin
				char_row <= char_row + 1'b1;
			end
		end
	end

	assign cell_index = row_base + column;

endmodule

`default_nettype wire

// ==== logic/video_pkg.sv ====
`default_nettype none

package video_pkg;

	// ==============================
	// Raster timing
	// ==============================
	localparam int HORZ_BACK_PORCH = 8;
	localparam int HORZ_VISIBLE = 128;
	localparam int HORZ_FRONT_PORCH = 4;
	localparam int HORZ_SYNC = 8;
	localparam int HORZ_TOTAL = HORZ_BACK_PORCH + HORZ_VISIBLE + HORZ_FRONT_PORCH + HORZ_SYNC;
	localparam int HORZ_VISIBLE_START = HORZ_BACK_PORCH;
	localparam int HORZ_SYNC_START = HORZ_BACK_PORCH + HORZ_VISIBLE + HORZ_FRONT_PORCH;

	localparam int VERT_BACK_PORCH = 2;
	localparam int VERT_VISIBLE = 40;
	localparam int VERT_FRONT_PORCH = 1;
	localparam int VERT_SYNC = 2;
	localparam int VERT_TOTAL = VERT_BACK_PORCH + VERT_VISIBLE + VERT_FRONT_PORCH + VERT_SYNC;
	localparam int VERT_VISIBLE_START = VERT_BACK_PORCH;
	localparam int VERT_SYNC_START = VERT_BACK_PORCH + VERT_VISIBLE + VERT_FRONT_PORCH;

	localparam int XPOS_WIDTH = $clog2(HORZ_TOTAL);
	localparam int YPOS_WIDTH = $clog2(VERT_TOTAL);

	// Counter to output latency of the pixel pipeline
	localparam int SYNC_DELAY = 4;

	// ==============================
	// Text grid and font
	// ==============================
	localparam int CHAR_WIDTH = 16;
	localparam int CHAR_HEIGHT = 20;
	localparam int CHAR_ROW_WIDTH = $clog2(CHAR_HEIGHT);
	localparam int PIXEL_SEL_WIDTH = $clog2(CHAR_WIDTH);
	localparam int COLUMNS = 8;
	localparam int ROWS = 2;
	localparam int CELL_COUNT = COLUMNS * ROWS;
	localparam int CELL_ADDR_WIDTH = $clog2(CELL_COUNT);
	localparam logic [CELL_ADDR_WIDTH-1:0] ROW_STRIDE = CELL_ADDR_WIDTH'(COLUMNS);
	localparam int CELL_WIDTH = 32;
	localparam int FONT_ADDR_WIDTH = 15;
	localparam int UNDERLINE_ROW = 17;

	// Cell word fields
	localparam int BG_MSB = 31;
	localparam int BG_LSB = 28;
	localparam int FG_MSB = 27;
	localparam int FG_LSB = 24;
	localparam int UNDERLINE_BIT = 17;
	localparam int INVERT_BIT = 16;
	localparam int CODE_WIDTH = 10;

	// Cursor command fields
	localparam int CURSOR_VISIBLE_BIT = 13;
	localparam int CURSOR_ROW_MSB = 12;
	localparam int CURSOR_ROW_LSB = 7;
	localparam int CURSOR_COL_MSB = 6;
	localparam int CURSOR_LINEAR_WIDTH = CURSOR_ROW_MSB + 1;
	localparam logic [CURSOR_LINEAR_WIDTH-1:0] CURSOR_STRIDE = CURSOR_LINEAR_WIDTH'(COLUMNS);

	// ==============================
	// Colours and commands
	// ==============================
	localparam int COLOR_DEPTH = 9;
	localparam int CHANNEL_WIDTH = COLOR_DEPTH / 3;
	localparam int PALETTE_SIZE = 16;
	localparam int COLOR_INDEX_WIDTH = $clog2(PALETTE_SIZE);

	typedef enum logic [1:0] {
		OP_WRITE_CELL = 2'd0,
		OP_CURSOR_POSITION = 2'd1
	} video_op_e;

endpackage

`default_nettype wire

// ==== include/ansi_palette.svh ====
// ==============================
// ANSI colour palette
// ==============================

// Entries are {red, green, blue}, one octal digit per channel
// Dark set in 0-7, bright set in 8-15
localparam logic [video_pkg::COLOR_DEPTH-1:0] ANSI_PALETTE [video_pkg::PALETTE_SIZE] = '{
	9'o000,
	9'o500,
	9'o050,
	9'o550,
	9'o005,
	9'o505,
	9'o055,
	9'o555,
	9'o222,
	9'o722,
	9'o272,
	9'o772,
	9'o227,
	9'o727,
	9'o277,
	9'o777
};
